// ==== design/vic_raster_consts.svh ====
`ifndef VIC_RASTER_CONSTS_SVH
`define VIC_RASTER_CONSTS_SVH

// raster position widths
`define VIC_X_W 10
`define VIC_Y_W 9

// cpu register map, only the raster related registers remain
`define VIC_REG_RASTER_HI 6'h11
`define VIC_REG_RASTER_LO 6'h12
`define VIC_REG_IRQ_LATCH 6'h19
`define VIC_REG_IRQ_EN    6'h1a

// last tick of phi high, where cpu writes land
`define VIC_WRITE_TICK 5'd31

// 6567R56A, 512 dots by 262 lines
`define VIC_R56A_X_MAX        10'd511
`define VIC_R56A_Y_MAX        9'd261
`define VIC_R56A_HSYNC_START  10'd409
`define VIC_R56A_HSYNC_END    10'd446
`define VIC_R56A_VBLANK_START 9'd14

// 6567R8, 520 dots by 263 lines
`define VIC_R8_X_MAX        10'd519
`define VIC_R8_Y_MAX        9'd262
`define VIC_R8_HSYNC_START  10'd409
`define VIC_R8_HSYNC_END    10'd446
`define VIC_R8_VBLANK_START 9'd14

// 6569, 504 dots by 312 lines
`define VIC_6569_X_MAX        10'd503
`define VIC_6569_Y_MAX        9'd311
`define VIC_6569_HSYNC_START  10'd408
`define VIC_6569_HSYNC_END    10'd444
`define VIC_6569_VBLANK_START 9'd301

// number of lines with inverted sync pulses
`define VIC_VSYNC_LINES 3

`endif

// ==== design/vic_raster_pkg.sv ====
`include "vic_raster_consts.svh"

package vic_raster_pkg;

    // chip type, the unused code falls back to pal timing
    typedef enum logic [1:0] {
        CHIP_6567R56A = 2'd0,
        CHIP_6567R8   = 2'd1,
        CHIP_6569     = 2'd2,
        CHIP_UNUSED   = 2'd3
    } chip_t;

    // raster limits for one chip type
    typedef struct packed {
        logic [`VIC_X_W-1:0] x_max;
        logic [`VIC_Y_W-1:0] y_max;
        logic [`VIC_X_W-1:0] hsync_start;
        logic [`VIC_X_W-1:0] hsync_end;
        logic [`VIC_Y_W-1:0] vblank_start;
    } chip_limits_t;

    // current beam position
    typedef struct packed {
        logic [`VIC_X_W-1:0] x;
        logic [`VIC_Y_W-1:0] line;
    } raster_pos_t;

    // strobes derived from the tick counter
    typedef struct packed {
        // dot tick, raster position moves
        logic advance;
        // cpu write lands on this edge
        logic write_slot;
        // level of clk_phi
        logic phi;
    } phase_t;

    // cpu side of the register port, ce is active low, rw high reads
    typedef struct packed {
        logic       ce;
        logic       rw;
        logic [5:0] adi;
        logic [7:0] dbi;
    } cpu_bus_t;

    function automatic chip_limits_t chip_limits(chip_t chip);
        chip_limits_t lim;
        case (chip)
            CHIP_6567R56A: begin
                lim.x_max        = `VIC_R56A_X_MAX;
                lim.y_max        = `VIC_R56A_Y_MAX;
                lim.hsync_start  = `VIC_R56A_HSYNC_START;
                lim.hsync_end    = `VIC_R56A_HSYNC_END;
                lim.vblank_start = `VIC_R56A_VBLANK_START;
            end
            CHIP_6567R8: begin
                lim.x_max        = `VIC_R8_X_MAX;
                lim.y_max        = `VIC_R8_Y_MAX;
                lim.hsync_start  = `VIC_R8_HSYNC_START;
                lim.hsync_end    = `VIC_R8_HSYNC_END;
                lim.vblank_start = `VIC_R8_VBLANK_START;
            end
            default: begin
                // 6569 and the unused code
                lim.x_max        = `VIC_6569_X_MAX;
                lim.y_max        = `VIC_6569_Y_MAX;
                lim.hsync_start  = `VIC_6569_HSYNC_START;
                lim.hsync_end    = `VIC_6569_HSYNC_END;
                lim.vblank_start = `VIC_6569_VBLANK_START;
            end
        endcase
        return lim;
    endfunction

endpackage

// ==== design/phase_gen.sv ====
`include "vic_raster_consts.svh"

module phase_gen (
    input  logic                    clk_dot4x,
    input  logic                    rst,
    input  vic_raster_pkg::cpu_bus_t bus,
    output vic_raster_pkg::phase_t  phase,
    output logic                    clk_phi,
    output logic                    clk_dot
);

    // 32 ticks of clk_dot4x make one phi cycle
    logic [4:0] tick;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick <= 5'd0;
        end else begin
            tick <= tick + 5'd1;
        end
    end

    // clocks come straight from counter flops, so both start low
    assign clk_phi = tick[4];
    assign clk_dot = tick[1];

    // last quarter of each dot period moves the beam
    assign phase.advance = (tick[1:0] == 2'b11);

    // write slot needs a selected cpu write
    assign phase.write_slot = (tick == `VIC_WRITE_TICK) && !bus.ce && !bus.rw;

    assign phase.phi = tick[4];

endmodule

// ==== design/cpu_regs.sv ====
`include "vic_raster_consts.svh"

module cpu_regs (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_raster_pkg::cpu_bus_t    bus,
    input  vic_raster_pkg::phase_t      phase,
    input  vic_raster_pkg::raster_pos_t pos,
    input  logic                        irst,
    output logic [8:0]                  compare,
    output logic                        erst,
    output logic                        irst_clr,
    output logic [7:0]                  dbo
);

    logic       rd_en;
    logic [7:0] rd_data;

    // writes, all on the write slot edge
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            compare <= 9'd0;
            erst    <= 1'b0;
        end else if (phase.write_slot) begin
            case (bus.adi)
                // only bit 7 of $d011 belongs to the raster compare
                `VIC_REG_RASTER_HI: compare[8]   <= bus.dbi[7];
                `VIC_REG_RASTER_LO: compare[7:0] <= bus.dbi;
                `VIC_REG_IRQ_EN:    erst         <= bus.dbi[0];
                default: ;
            endcase
        end
    end

    // writing a one to the latch bit acknowledges the interrupt
    assign irst_clr = phase.write_slot
                      && (bus.adi == `VIC_REG_IRQ_LATCH)
                      && bus.dbi[0];

    // read mux
    always_comb begin
        case (bus.adi)
            `VIC_REG_RASTER_HI: rd_data = {pos.line[8], 7'd0};
            `VIC_REG_RASTER_LO: rd_data = pos.line[7:0];
            // bit 7 mirrors the irq pin level
            `VIC_REG_IRQ_LATCH: rd_data = {irst & erst, 6'd0, irst};
            `VIC_REG_IRQ_EN:    rd_data = {7'd0, erst};
            // unmapped addresses float high
            default:            rd_data = 8'hff;
        endcase
    end

    assign rd_en = !bus.ce && bus.rw;

    // read data lags the access by one clk_dot4x cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dbo <= 8'd0;
        end else if (rd_en) begin
            dbo <= rd_data;
        end
    end

endmodule

// ==== design/raster_counter.sv ====
module raster_counter (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_raster_pkg::chip_t       chip,
    input  vic_raster_pkg::phase_t      phase,
    output vic_raster_pkg::raster_pos_t pos,
    output logic                        line_start
);

    vic_raster_pkg::chip_limits_t lim;
    logic                         x_wrap;

    assign lim = vic_raster_pkg::chip_limits(chip);

    // end of the line on this dot
    assign x_wrap = (pos.x >= lim.x_max);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pos.x      <= 10'd0;
            pos.line   <= 9'd0;
            line_start <= 1'b0;
        end else begin
            // flag the cycle that shows x back at 0
            line_start <= phase.advance && x_wrap;
            if (phase.advance) begin
                if (x_wrap) begin
                    pos.x <= 10'd0;
                    // last line of the frame goes back to 0
                    if (pos.line >= lim.y_max) begin
                        pos.line <= 9'd0;
                    end else begin
                        pos.line <= pos.line + 9'd1;
                    end
                end else begin
                    pos.x <= pos.x + 10'd1;
                end
            end
        end
    end

endmodule

// ==== design/raster_irq.sv ====
module raster_irq (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_raster_pkg::raster_pos_t pos,
    input  logic                        line_start,
    input  logic [8:0]                  compare,
    input  logic                        erst,
    input  logic                        irst_clr,
    output logic                        irst,
    output logic                        irq
);

    logic match;

    // compare only once per line, at its first cycle
    assign match = line_start && (pos.line == compare);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst <= 1'b0;
        end else if (match) begin
            // a new match beats an acknowledge on the same edge
            irst <= 1'b1;
        end else if (irst_clr) begin
            irst <= 1'b0;
        end
    end

    // latch keeps counting even while disabled,
    // so enabling later fires at once
    assign irq = irst & erst;

endmodule

// ==== design/csync_gen.sv ====
`include "vic_raster_consts.svh"

module csync_gen (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_raster_pkg::chip_t       chip,
    input  vic_raster_pkg::raster_pos_t pos,
    output logic                        csync
);

    vic_raster_pkg::chip_limits_t lim;
    logic [9:0]                   vsync_end;
    logic                         in_hsync;
    logic                         in_vsync;

    assign lim = vic_raster_pkg::chip_limits(chip);

    // one bit wider so the sum never wraps
    assign vsync_end = {1'b0, lim.vblank_start} + 10'(`VIC_VSYNC_LINES);

    assign in_hsync = (pos.x >= lim.hsync_start) && (pos.x < lim.hsync_end);
    assign in_vsync = ({1'b0, pos.line} >= {1'b0, lim.vblank_start})
                      && ({1'b0, pos.line} < vsync_end);

    // serrated vsync, pulse polarity flips on the vsync lines
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            csync <= 1'b1;
        end else begin
            csync <= ~(in_hsync ^ in_vsync);
        end
    end

endmodule

// ==== design/vic_raster_top.sv ====
module vic_raster_top (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  vic_raster_pkg::chip_t chip,
    input  logic                  ce,
    input  logic                  rw,
    input  logic [5:0]            adi,
    input  logic [7:0]            dbi,
    output logic [7:0]            dbo,
    output logic                  irq,
    output logic                  csync,
    output logic                  clk_phi,
    output logic                  clk_dot
);

    vic_raster_pkg::cpu_bus_t    bus;
    vic_raster_pkg::phase_t      phase;
    vic_raster_pkg::raster_pos_t pos;
    logic                        line_start;
    logic [8:0]                  compare;
    logic                        erst;
    logic                        irst;
    logic                        irst_clr;

    // pins gathered into one bus struct
    assign bus = '{ce: ce, rw: rw, adi: adi, dbi: dbi};

    phase_gen i_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .bus       (bus),
        .phase     (phase),
        .clk_phi   (clk_phi),
        .clk_dot   (clk_dot)
    );

    cpu_regs i_cpu_regs (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .bus       (bus),
        .phase     (phase),
        .pos       (pos),
        .irst      (irst),
        .compare   (compare),
        .erst      (erst),
        .irst_clr  (irst_clr),
        .dbo       (dbo)
    );

    raster_counter i_raster_counter (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .chip       (chip),
        .phase      (phase),
        .pos        (pos),
        .line_start (line_start)
    );

    raster_irq i_raster_irq (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .pos        (pos),
        .line_start (line_start),
        .compare    (compare),
        .erst       (erst),
        .irst_clr   (irst_clr),
        .irst       (irst),
        .irq        (irq)
    );

    csync_gen i_csync_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .pos       (pos),
        .csync     (csync)
    );

endmodule

// ==== verification/tb_vic_raster.sv ====
`include "vic_raster_consts.svh"

module tb_vic_raster;

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk_dot4x;
    logic                  rst;
    vic_raster_pkg::chip_t chip;
    logic                  ce;
    logic                  rw;
    logic [5:0]            adi;
    logic [7:0]            dbi;
    logic [7:0]            dbo;
    logic                  irq;
    logic                  csync;
    logic                  clk_phi;
    logic                  clk_dot;

    // model state, follows the raster timing rules
    logic [4:0]  m_tick;
    logic [9:0]  m_x;
    logic [8:0]  m_line;
    logic        m_line_start;
    logic        m_csync;
    logic [8:0]  m_compare;
    logic        m_erst;
    logic        m_irst;
    logic [7:0]  m_dbo;

    // limits of the chip under test
    logic [9:0]  lx_max;
    logic [8:0]  ly_max;
    logic [9:0]  lhs_start;
    logic [9:0]  lhs_end;
    logic [8:0]  lvb_start;

    logic [31:0] lfsr_state = 32'h76a9;
    int          cycles = 0;
    int          run_start = 0;
    int          cycle_limit = 0;

    vic_raster_top i_vic_raster_top (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .ce        (ce),
        .rw        (rw),
        .adi       (adi),
        .dbi       (dbi),
        .dbo       (dbo),
        .irq       (irq),
        .csync     (csync),
        .clk_phi   (clk_phi),
        .clk_dot   (clk_dot)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("Verification failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic set_limits(input vic_raster_pkg::chip_t c);
        case (c)
            vic_raster_pkg::CHIP_6567R56A: begin
                lx_max    = `VIC_R56A_X_MAX;
                ly_max    = `VIC_R56A_Y_MAX;
                lhs_start = `VIC_R56A_HSYNC_START;
                lhs_end   = `VIC_R56A_HSYNC_END;
                lvb_start = `VIC_R56A_VBLANK_START;
            end
            vic_raster_pkg::CHIP_6567R8: begin
                lx_max    = `VIC_R8_X_MAX;
                ly_max    = `VIC_R8_Y_MAX;
                lhs_start = `VIC_R8_HSYNC_START;
                lhs_end   = `VIC_R8_HSYNC_END;
                lvb_start = `VIC_R8_VBLANK_START;
            end
            default: begin
                lx_max    = `VIC_6569_X_MAX;
                ly_max    = `VIC_6569_Y_MAX;
                lhs_start = `VIC_6569_HSYNC_START;
                lhs_end   = `VIC_6569_HSYNC_END;
                lvb_start = `VIC_6569_VBLANK_START;
            end
        endcase
    endtask

    // four clk_dot4x cycles per dot
    function automatic int frame_cycles();
        return (int'(lx_max) + 1) * (int'(ly_max) + 1) * 4;
    endfunction

    function automatic logic is_mapped(input logic [5:0] a);
        return a == `VIC_REG_RASTER_HI || a == `VIC_REG_RASTER_LO
               || a == `VIC_REG_IRQ_LATCH || a == `VIC_REG_IRQ_EN;
    endfunction

    // model update for one rising edge, every term uses the state before the edge
    task automatic model_edge();
        logic adv;
        logic wslot;
        logic hs;
        logic vs;
        logic [7:0] rd;
        adv   = (m_tick[1:0] == 2'b11);
        wslot = (m_tick == 5'd31) && !ce && !rw;
        if (rst) begin
            m_tick       = 5'd0;
            m_x          = 10'd0;
            m_line       = 9'd0;
            m_line_start = 1'b0;
            m_csync      = 1'b1;
            m_compare    = 9'd0;
            m_erst       = 1'b0;
            m_irst       = 1'b0;
            m_dbo        = 8'd0;
        end else begin
            case (adi)
                `VIC_REG_RASTER_HI: rd = {m_line[8], 7'd0};
                `VIC_REG_RASTER_LO: rd = m_line[7:0];
                `VIC_REG_IRQ_LATCH: rd = {m_irst & m_erst, 6'd0, m_irst};
                `VIC_REG_IRQ_EN:    rd = {7'd0, m_erst};
                default:            rd = 8'hff;
            endcase
            if (!ce && rw) begin
                m_dbo = rd;
            end
            // set wins over the acknowledge
            if (m_line_start && m_line == m_compare) begin
                m_irst = 1'b1;
            end else if (wslot && adi == `VIC_REG_IRQ_LATCH && dbi[0]) begin
                m_irst = 1'b0;
            end
            hs = (m_x >= lhs_start) && (m_x < lhs_end);
            vs = (m_line >= lvb_start)
                 && ({1'b0, m_line} < {1'b0, lvb_start} + 10'(`VIC_VSYNC_LINES));
            // low on hsync outside vsync, and off hsync inside vsync
            m_csync = !((!vs && hs) || (vs && !hs));
            if (wslot) begin
                case (adi)
                    `VIC_REG_RASTER_HI: m_compare[8]   = dbi[7];
                    `VIC_REG_RASTER_LO: m_compare[7:0] = dbi;
                    `VIC_REG_IRQ_EN:    m_erst         = dbi[0];
                    default: ;
                endcase
            end
            m_line_start = adv && (m_x == lx_max);
            if (adv) begin
                if (m_x == lx_max) begin
                    m_x    = 10'd0;
                    m_line = (m_line == ly_max) ? 9'd0 : m_line + 9'd1;
                end else begin
                    m_x = m_x + 10'd1;
                end
            end
            m_tick = m_tick + 5'd1;
        end
    endtask

    // one clock: model on the rising edge, compare on the falling edge
    task automatic step();
        @(posedge clk_dot4x);
        model_edge();
        @(negedge clk_dot4x);
        cycles++;
        if (cycles > cycle_limit) begin
            report_problem("timeout, simulation ran past its cycle limit");
        end
        assert (clk_phi == m_tick[4])
            else report_mismatch("clk_phi", 32'(clk_phi), 32'(m_tick[4]));
        assert (clk_dot == m_tick[1])
            else report_mismatch("clk_dot", 32'(clk_dot), 32'(m_tick[1]));
        assert (csync == m_csync) else report_mismatch("csync", 32'(csync), 32'(m_csync));
        assert (irq == (m_irst & m_erst))
            else report_mismatch("irq", 32'(irq), 32'(m_irst & m_erst));
        assert (dbo == m_dbo) else report_mismatch("dbo", 32'(dbo), 32'(m_dbo));
    endtask

    // one bus access spans a whole phi cycle
    task automatic cpu_access(input logic wr, input logic [5:0] addr, input logic [7:0] data);
        ce  = 1'b0;
        rw  = !wr;
        adi = addr;
        dbi = data;
        repeat (32) step();
        ce = 1'b1;
        rw = 1'b1;
    endtask

    // compare value a few lines ahead of the beam
    task automatic arm_compare(output logic [8:0] tgt);
        logic [31:0] r;
        take_bits(4, r);
        tgt = 9'((int'(m_line) + 2 + int'(r[3:0])) % (int'(ly_max) + 1));
        cpu_access(1'b1, `VIC_REG_RASTER_HI, {tgt[8], 7'd0});
        cpu_access(1'b1, `VIC_REG_RASTER_LO, tgt[7:0]);
        // drop a match from the half written compare value
        cpu_access(1'b1, `VIC_REG_IRQ_LATCH, 8'h01);
    endtask

    task automatic run_chip(input vic_raster_pkg::chip_t c);
        logic [8:0]  tgt;
        logic [31:0] r;
        logic [5:0]  addr;
        chip = c;
        rst  = 1'b1;
        ce   = 1'b1;
        rw   = 1'b1;
        set_limits(c);
        repeat (2) step();
        rst       = 1'b0;
        run_start = cycles;
        // enabled interrupt on a random line, then acknowledge
        arm_compare(tgt);
        cpu_access(1'b1, `VIC_REG_IRQ_EN, 8'h01);
        while (!irq) step();
        // beam is still on the compare line right after irq goes high
        cpu_access(1'b0, `VIC_REG_RASTER_LO, 8'h00);
        assert (dbo == tgt[7:0]) else report_mismatch("dbo", 32'(dbo), 32'(tgt[7:0]));
        cpu_access(1'b0, `VIC_REG_RASTER_HI, 8'h00);
        assert (dbo == {tgt[8], 7'd0})
            else report_mismatch("dbo", 32'(dbo), 32'({tgt[8], 7'd0}));
        cpu_access(1'b1, `VIC_REG_IRQ_LATCH, 8'h01);
        assert (irq == 1'b0) else report_mismatch("irq", 32'(irq), 32'd0);
        // disabled interrupt, latch visible, enable fires at once
        cpu_access(1'b1, `VIC_REG_IRQ_EN, 8'h00);
        arm_compare(tgt);
        while (!m_irst) step();
        cpu_access(1'b0, `VIC_REG_IRQ_LATCH, 8'h00);
        assert (dbo == 8'h01) else report_mismatch("dbo", 32'(dbo), 32'h01);
        cpu_access(1'b1, `VIC_REG_IRQ_EN, 8'h01);
        assert (irq == 1'b1) else report_mismatch("irq", 32'(irq), 32'd1);
        cpu_access(1'b1, `VIC_REG_IRQ_LATCH, 8'h01);
        // random reads and idle time fill out two frames
        while (cycles - run_start < 2 * frame_cycles()) begin
            take_bits(2, r);
            case (r[1:0])
                2'd0: cpu_access(1'b0, `VIC_REG_RASTER_LO, 8'h00);
                2'd1: cpu_access(1'b0, `VIC_REG_RASTER_HI, 8'h00);
                2'd2: begin
                    take_bits(6, r);
                    addr = r[5:0];
                    if (is_mapped(addr)) begin
                        addr = addr ^ 6'h20;
                    end
                    cpu_access(1'b0, addr, 8'h00);
                    assert (dbo == 8'hff) else report_mismatch("dbo", 32'(dbo), 32'hff);
                end
                default: begin
                    take_bits(5, r);
                    repeat (int'(r[4:0]) + 1) step();
                end
            endcase
        end
    endtask

    initial begin
        rst  = 1'b1;
        chip = vic_raster_pkg::CHIP_6567R56A;
        ce   = 1'b1;
        rw   = 1'b1;
        adi  = 6'd0;
        dbi  = 8'd0;
        // two frames per chip, plus a tenth
        set_limits(vic_raster_pkg::CHIP_6567R56A);
        cycle_limit = 2 * frame_cycles();
        set_limits(vic_raster_pkg::CHIP_6567R8);
        cycle_limit += 2 * frame_cycles();
        set_limits(vic_raster_pkg::CHIP_6569);
        cycle_limit += 2 * frame_cycles();
        cycle_limit += cycle_limit / 10;
        run_chip(vic_raster_pkg::CHIP_6567R56A);
        run_chip(vic_raster_pkg::CHIP_6567R8);
        run_chip(vic_raster_pkg::CHIP_6569);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== vic_raster.f ====
+incdir+design
design/vic_raster_pkg.sv
design/phase_gen.sv
design/cpu_regs.sv
design/raster_counter.sv
design/raster_irq.sv
design/csync_gen.sv
design/vic_raster_top.sv
verification/tb_vic_raster.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_vic_raster
FILELIST  = vic_raster.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
